//--- hw/kicker_io_pkg.sv
// shared types for the kicker I/O block, imported by the RTL stages and the testbench
`default_nettype none

package kicker_io_pkg;

    // one decoded region per bus access, rgn_none when idle or unmapped
    typedef enum logic [3:0] {
        rgn_none,
        rgn_rom,        // 4000-ffff reads
        rgn_iow,        // control byte
        rgn_intshow,    // scroll chip readback
        rgn_psg2_wr,    // sound chip 2 strobe
        rgn_psg1_wr,    // sound chip 1 strobe
        rgn_dip2,
        rgn_dip3,
        rgn_ior,        // cabinet ports
        rgn_psg2_data,
        rgn_psg1_data,
        rgn_color,      // palette select
        rgn_vscr,
        rgn_obj1,
        rgn_obj2,
        rgn_vram
    } io_region_e;

    // system port, active low inputs as wired on the cabinet
    typedef struct packed {
        logic [2:0] fill;
        logic [1:0] start;
        logic       service;
        logic [1:0] coin;
    } cab_sys_s;

    // joystick port after the board's bit swap
    typedef struct packed {
        logic [1:0] fill;
        logic [1:0] button;
        logic       down;
        logic       up;
        logic       right;
        logic       left;
    } cab_joy_s;

    // one cabinet byte, read as system or joystick depending on addr[1:0]
    typedef union packed {
        cab_sys_s sys;
        cab_joy_s joy;
    } cab_port_u;

    // iow control byte layout
    localparam int flip_bit    = 0;
    localparam int firq_en_bit = 1;
    localparam int irq_en_bit  = 2;

endpackage

`default_nettype wire

//--- hw/kicker_bus_decode.sv
// address decoder, maps the cpu bus address onto one region and drives the graphics selects
`timescale 1ns/10ps
`default_nettype none

module kicker_bus_decode (
    input  wire [15:0]                addr,
    input  wire                       rnw,
    input  wire                       valid,
    output kicker_io_pkg::io_region_e region,
    output logic                      rom_cs,
    output logic                      vram_cs,
    output logic                      vscr_cs,
    output logic                      obj1_cs,
    output logic                      obj2_cs
);
    import kicker_io_pkg::*;

    // rom covers everything above 3fff, reads only
    assign rom_cs = valid & rnw & (addr[15:14] != 2'b00);

    always_comb begin
        region = rgn_none;
        if (valid) begin
            if (rom_cs) begin
                region = rgn_rom;
            end else begin
                case (addr[13:11])
                    3'd0: begin
                        // page 0 is split by addr[10:8]
                        case (addr[10:8])
                            3'd0: region = rgn_iow;
                            3'd1: region = rgn_none;    // watchdog, not used
                            3'd2: region = rgn_intshow;
                            3'd3: region = rgn_psg2_wr;
                            3'd4: region = rgn_psg1_wr;
                            3'd5: region = rgn_dip2;
                            3'd6: region = rgn_dip3;
                            3'd7: region = rgn_ior;
                            default: region = rgn_none;
                        endcase
                    end
                    3'd1: region = rgn_psg2_data;
                    3'd2: region = rgn_psg1_data;
                    3'd3: region = rgn_color;
                    3'd4: region = rgn_vscr;     // vertical scroll
                    3'd5: region = rgn_obj1;
                    3'd6: region = rgn_obj2;
                    3'd7: region = rgn_vram;
                    default: region = rgn_none;
                endcase
            end
        end
    end

    // graphics chips see their select straight from the decode
    assign vram_cs = (region == rgn_vram);
    assign vscr_cs = (region == rgn_vscr);
    assign obj1_cs = (region == rgn_obj1);
    assign obj2_cs = (region == rgn_obj2);

endmodule

`default_nettype wire

//--- hw/kicker_ctrl_exec.sv
// execute stage, holds control bits, interrupt flags and the sound chip latches and strobes
`timescale 1ns/10ps
`default_nettype none

module kicker_ctrl_exec #(
    parameter int pal_w = 3
) (
    input  wire                           clk,
    input  wire                           rst,
    input  var kicker_io_pkg::io_region_e region,
    input  wire                           rnw,
    input  wire                           valid,
    input  wire [7:0]                     wdata,
    input  wire                           lvbl,
    input  wire                           v16,
    input  wire                           dip_pause,
    input  wire                           psg1_rdy,
    input  wire                           psg2_rdy,
    output logic                          flip,
    output logic [pal_w-1:0]              pal_sel,
    output logic                          irq_n,
    output logic                          firq_n,
    output logic [7:0]                    psg1_din,
    output logic [7:0]                    psg2_din,
    output logic                          psg1_wr,
    output logic                          psg2_wr,
    output logic                          psg_stall
);
    import kicker_io_pkg::*;

    logic       wr_done;    // write of this access already taken
    logic       wr_first;
    logic       irq_en;
    logic       firq_en;
    logic       irq_flag;
    logic       firq_flag;
    logic       lvbl_q;
    logic       v16_q;
    logic [1:0] psg_hit;    // index 0 is chip 1
    logic [1:0] psg_rdy;
    logic [1:0] psg_wait;
    logic [1:0] psg_wr;

    assign wr_first = valid & ~rnw & ~wr_done;
    assign psg_hit  = {region == rgn_psg2_wr, region == rgn_psg1_wr};
    assign psg_rdy  = {psg2_rdy, psg1_rdy};

    // one write per access, rearmed when valid drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_done <= 1'b0;
        end else begin
            wr_done <= valid & ~rnw;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip    <= 1'b0;
            irq_en  <= 1'b0;
            firq_en <= 1'b0;
            pal_sel <= '0;
        end else if (wr_first) begin
            if (region == rgn_iow) begin
                flip    <= wdata[flip_bit];
                firq_en <= wdata[firq_en_bit];
                irq_en  <= wdata[irq_en_bit];
            end
            if (region == rgn_color) begin
                pal_sel <= wdata[pal_w-1:0];
            end
        end
    end

    // vblank start and v16 rise, both masked by the pause switch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_q    <= 1'b1;
            v16_q     <= 1'b0;
            irq_flag  <= 1'b0;
            firq_flag <= 1'b0;
        end else begin
            lvbl_q <= lvbl;
            v16_q  <= v16;
            if (!irq_en) begin
                irq_flag <= 1'b0;   // disabled flag stays clear
            end else if (lvbl_q && !lvbl && dip_pause) begin
                irq_flag <= 1'b1;
            end
            if (!firq_en) begin
                firq_flag <= 1'b0;
            end else if (!v16_q && v16 && dip_pause) begin
                firq_flag <= 1'b1;
            end
        end
    end

    assign irq_n  = ~(irq_flag & irq_en);
    assign firq_n = ~(firq_flag & firq_en);

    always_ff @(posedge clk) begin
        if (wr_first && region == rgn_psg1_data) psg1_din <= wdata;
        if (wr_first && region == rgn_psg2_data) psg2_din <= wdata;
    end

    // strobe handshake, wait stays up through the pulse so ready trails it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            psg_wait <= 2'b00;
            psg_wr   <= 2'b00;
        end else begin
            for (int i = 0; i < 2; i++) begin
                psg_wr[i] <= 1'b0;
                if (wr_first && psg_hit[i]) begin
                    if (psg_rdy[i]) psg_wr[i] <= 1'b1;
                    else psg_wait[i] <= 1'b1;   // chip busy
                end else if (psg_wait[i]) begin
                    if (psg_wr[i]) psg_wait[i] <= 1'b0;
                    else if (psg_rdy[i]) psg_wr[i] <= 1'b1;
                end
            end
        end
    end

    assign psg1_wr   = psg_wr[0];
    assign psg2_wr   = psg_wr[1];
    assign psg_stall = |psg_wait;

endmodule

`default_nettype wire

//--- hw/kicker_read_mux.sv
// result stage, latches the cabinet byte, registers read data and times the ready pulse
`timescale 1ns/10ps
`default_nettype none

module kicker_read_mux (
    input  wire                           clk,
    input  wire                           rst,
    input  wire [15:0]                    addr,
    input  var kicker_io_pkg::io_region_e region,
    input  wire                           valid,
    input  wire                           rnw,
    input  wire [7:0]                     rom_data,
    input  wire                           rom_ok,
    input  wire [7:0]                     vram_dout,
    input  wire [7:0]                     vscr_dout,
    input  wire [7:0]                     obj_dout,
    input  wire [1:0]                     start_button,
    input  wire [1:0]                     coin_input,
    input  wire                           service,
    input  wire [5:0]                     joystick1,
    input  wire [5:0]                     joystick2,
    input  wire [7:0]                     dipsw_a,
    input  wire [7:0]                     dipsw_b,
    input  wire [3:0]                     dipsw_c,
    input  wire                           psg_stall,
    output logic [7:0]                    rdata,
    output logic                          ready
);
    import kicker_io_pkg::*;

    cab_port_u  cab_next;
    cab_port_u  cab_q;
    logic [7:0] rd_sel;
    logic       busy;       // io access in its first cycle or stalled
    logic       pending;    // acked, waiting for valid to drop
    logic       ack;

    // joystick bits are swapped pairwise on the board
    function automatic cab_joy_s joy_view(input logic [5:0] j);
        cab_joy_s v;
        v.fill   = 2'b11;
        v.button = j[5:4];
        v.down   = j[2];
        v.up     = j[3];
        v.right  = j[0];
        v.left   = j[1];
        return v;
    endfunction

    always_comb begin
        cab_next = dipsw_a;
        case (addr[1:0])
            2'd0: begin
                cab_next.sys.fill    = 3'b111;
                cab_next.sys.start   = start_button;
                cab_next.sys.service = service;
                cab_next.sys.coin    = coin_input;
            end
            2'd1: cab_next.joy = joy_view(joystick1);
            2'd2: cab_next.joy = joy_view(joystick2);
            default: cab_next = dipsw_a;
        endcase
    end

    always_comb begin
        case (region)
            rgn_rom:     rd_sel = rom_data;
            rgn_vram:    rd_sel = vram_dout;
            rgn_intshow: rd_sel = vscr_dout;
            rgn_obj1,
            rgn_obj2:    rd_sel = obj_dout;
            rgn_ior:     rd_sel = cab_q;
            rgn_dip2:    rd_sel = dipsw_b;
            rgn_dip3:    rd_sel = {4'hf, dipsw_c};
            default:     rd_sel = 8'hff;    // write only or unmapped
        endcase
    end

    // rom waits on rom_ok, io takes one latch cycle plus any psg stall
    assign ack = valid & ~pending & ((region == rgn_rom) ? rom_ok : (busy & ~psg_stall));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            pending <= 1'b0;
            ready   <= 1'b0;
        end else begin
            ready <= ack;
            if (!valid) begin
                busy    <= 1'b0;
                pending <= 1'b0;
            end else if (ack) begin
                busy    <= 1'b0;
                pending <= 1'b1;
            end else if (!pending && region != rgn_rom) begin
                busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid && !busy && !pending) cab_q <= cab_next;  // first cycle of access
        if (ack && rnw) rdata <= rd_sel;
    end

endmodule

`default_nettype wire

//--- hw/kicker_io_top.sv
// top level of the kicker I/O block, wires decode, execute and result stages to the board
`timescale 1ns/10ps
`default_nettype none

module kicker_io_top #(
    parameter int pal_w = 3
) (
    input  wire              clk,
    input  wire              rst,
    // cpu bus
    input  wire [15:0]       addr,
    input  wire              rnw,
    input  wire              valid,
    input  wire [7:0]        wdata,
    output logic [7:0]       rdata,
    output logic             ready,
    // rom
    output logic             rom_cs,
    input  wire [7:0]        rom_data,
    input  wire              rom_ok,
    // graphics
    output logic             vram_cs,
    output logic             vscr_cs,
    output logic             obj1_cs,
    output logic             obj2_cs,
    input  wire [7:0]        vram_dout,
    input  wire [7:0]        vscr_dout,
    input  wire [7:0]        obj_dout,
    // cabinet and switches
    input  wire [1:0]        start_button,
    input  wire [1:0]        coin_input,
    input  wire              service,
    input  wire [5:0]        joystick1,
    input  wire [5:0]        joystick2,
    input  wire [7:0]        dipsw_a,
    input  wire [7:0]        dipsw_b,
    input  wire [3:0]        dipsw_c,
    input  wire              dip_pause,
    // video timing
    input  wire              lvbl,
    input  wire              v16,
    // control and interrupts
    output logic             flip,
    output logic [pal_w-1:0] pal_sel,
    output logic             irq_n,
    output logic             firq_n,
    // sound chips
    output logic [7:0]       psg1_din,
    output logic             psg1_wr,
    input  wire              psg1_rdy,
    output logic [7:0]       psg2_din,
    output logic             psg2_wr,
    input  wire              psg2_rdy
);
    import kicker_io_pkg::*;

    io_region_e region;
    logic       psg_stall;

    kicker_bus_decode u_decode (
        .addr    (addr),
        .rnw     (rnw),
        .valid   (valid),
        .region  (region),
        .rom_cs  (rom_cs),
        .vram_cs (vram_cs),
        .vscr_cs (vscr_cs),
        .obj1_cs (obj1_cs),
        .obj2_cs (obj2_cs)
    );

    kicker_ctrl_exec #(.pal_w(pal_w)) u_exec (
        .clk       (clk),
        .rst       (rst),
        .region    (region),
        .rnw       (rnw),
        .valid     (valid),
        .wdata     (wdata),
        .lvbl      (lvbl),
        .v16       (v16),
        .dip_pause (dip_pause),
        .psg1_rdy  (psg1_rdy),
        .psg2_rdy  (psg2_rdy),
        .flip      (flip),
        .pal_sel   (pal_sel),
        .irq_n     (irq_n),
        .firq_n    (firq_n),
        .psg1_din  (psg1_din),
        .psg2_din  (psg2_din),
        .psg1_wr   (psg1_wr),
        .psg2_wr   (psg2_wr),
        .psg_stall (psg_stall)
    );

    kicker_read_mux u_result (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .region       (region),
        .valid        (valid),
        .rnw          (rnw),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .vram_dout    (vram_dout),
        .vscr_dout    (vscr_dout),
        .obj_dout     (obj_dout),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .psg_stall    (psg_stall),
        .rdata        (rdata),
        .ready        (ready)
    );

endmodule

`default_nettype wire

//--- sim/kicker_io_props.sv
// concurrent assertions bound onto the kicker I/O top level for simulation
`timescale 1ns/10ps
`default_nettype none

module kicker_io_props (
    input wire clk,
    input wire rst,
    input wire ready,
    input wire psg1_wr,
    input wire psg2_wr,
    input wire vram_cs,
    input wire vscr_cs,
    input wire obj1_cs,
    input wire obj2_cs,
    input wire irq_n,
    input wire irq_en
);
    // bus acknowledge and sound strobes are single cycle
    ready_single: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
        else $error("ready high for two consecutive cycles");
    psg1_wr_single: assert property (@(posedge clk) disable iff (rst) psg1_wr |=> !psg1_wr)
        else $error("psg1_wr longer than one cycle");
    psg2_wr_single: assert property (@(posedge clk) disable iff (rst) psg2_wr |=> !psg2_wr)
        else $error("psg2_wr longer than one cycle");

    gfx_onehot: assert property (@(posedge clk) disable iff (rst)
                                 $onehot0({vram_cs, vscr_cs, obj1_cs, obj2_cs}))
        else $error("more than one graphics select high");

    // the flag is cleared while disabled, so a fresh enable starts with irq_n high
    irq_masked: assert property (@(posedge clk) disable iff (rst) !irq_en |=> irq_n)
        else $error("irq_n low right after the irq enable was clear");

endmodule

bind kicker_io_top kicker_io_props u_props (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .psg1_wr (psg1_wr),
    .psg2_wr (psg2_wr),
    .vram_cs (vram_cs),
    .vscr_cs (vscr_cs),
    .obj1_cs (obj1_cs),
    .obj2_cs (obj2_cs),
    .irq_n   (irq_n),
    .irq_en  (u_exec.irq_en)
);

`default_nettype wire

//--- include/kicker_io_checks.svh
// compare tasks for the kicker I/O testbench, included inside the testbench module
`ifndef KICKER_IO_CHECKS_SVH
`define KICKER_IO_CHECKS_SVH

// common failure path, stops the run on the first mismatch
task automatic fail_report(input string name, input string exp_s, input string act_s);
    $display("FAIL %s: expected %s, got %s", name, exp_s, act_s);
    $display("Simulation failed");
    $fatal(1, "mismatch in %s", name);
endtask

// rdata and sound latch bytes
task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        fail_report(name, $sformatf("%02h", exp), $sformatf("%02h", act));
    end
endtask

// cabinet bytes, printed through the joystick view as well
task automatic check_cab(input string name,
                         input kicker_io_pkg::cab_port_u exp,
                         input kicker_io_pkg::cab_port_u act);
    string exp_s;
    string act_s;
    exp_s = $sformatf("%02h (btn %b dulr %b%b%b%b)", exp, exp.joy.button,
                      exp.joy.down, exp.joy.up, exp.joy.right, exp.joy.left);
    act_s = $sformatf("%02h (btn %b dulr %b%b%b%b)", act, act.joy.button,
                      act.joy.down, act.joy.up, act.joy.right, act.joy.left);
    if (act !== exp) begin
        fail_report(name, exp_s, act_s);
    end
endtask

// interrupt lines and strobes
task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        fail_report(name, $sformatf("%b", exp), $sformatf("%b", act));
    end
endtask

`endif

//--- sim/kicker_io_tb.sv
// table-driven testbench for the kicker I/O block, plays the cpu bus and the board around it
`timescale 1ns/10ps
`default_nettype none

module kicker_io_tb;
    import kicker_io_pkg::*;

    localparam int pal_w   = 3;
    localparam int rst_cyc = 3;

    typedef enum {op_read, op_write, op_lvbl, op_v16} op_e;
    typedef enum {k_none, k_data, k_rom, k_dip2, k_dip3, k_cab, k_flip, k_pal,
                  k_irq, k_firq, k_psg1, k_psg2} kind_e;

    typedef struct {
        string       name;
        op_e         op;
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        pause;
        int          rom_dly;
        int          rdy_dly;    // cycles the addressed psg holds rdy low
        kind_e       kind;
        logic [7:0]  exp;
    } test_t;

    logic             clk;
    logic             rst;
    logic [15:0]      addr;
    logic             rnw;
    logic             valid;
    logic [7:0]       wdata;
    logic [7:0]       rdata;
    logic             ready;
    logic             rom_cs;
    logic [7:0]       rom_data;
    logic             rom_ok;
    logic             vram_cs;
    logic             vscr_cs;
    logic             obj1_cs;
    logic             obj2_cs;
    logic [7:0]       vram_dout;
    logic [7:0]       vscr_dout;
    logic [7:0]       obj_dout;
    logic [1:0]       start_button;
    logic [1:0]       coin_input;
    logic             service;
    logic [5:0]       joystick1;
    logic [5:0]       joystick2;
    logic [7:0]       dipsw_a;
    logic [7:0]       dipsw_b;
    logic [3:0]       dipsw_c;
    logic             dip_pause;
    logic             lvbl;
    logic             v16;
    logic             flip;
    logic [pal_w-1:0] pal_sel;
    logic             irq_n;
    logic             firq_n;
    logic [7:0]       psg1_din;
    logic             psg1_wr;
    logic             psg1_rdy;
    logic [7:0]       psg2_din;
    logic             psg2_wr;
    logic             psg2_rdy;

    test_t       tests[$];
    logic [31:0] rng = 32'h7703_0301;
    int          access_max;
    int          cycle_limit = 0;
    int          cycles;

    `include "kicker_io_checks.svh"

    kicker_io_top #(.pal_w(pal_w)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift_next(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // rom contents, depends on the whole address
    function automatic logic [7:0] rom_byte(input logic [15:0] a);
        return a[15:8] ^ a[7:0] ^ 8'h96;
    endfunction

    assign rom_data = rom_byte(addr);

    // {rom, vram, vscr, obj1, obj2} from the konami map
    function automatic logic [4:0] select_expect(input logic [15:0] a, input logic rd);
        if (rd && a[15:14] != 2'b00) return 5'b10000;
        case (a[13:11])
            3'd4: return 5'b00100;
            3'd5: return 5'b00010;
            3'd6: return 5'b00001;
            3'd7: return 5'b01000;
            default: return 5'b00000;
        endcase
    endfunction

    // 1 or 2 for a strobe write to that chip, 0 otherwise
    function automatic int strobe_chip(input logic [15:0] a, input logic rd);
        if (rd || a[15:11] != 5'd0) return 0;
        if (a[10:8] == 3'd3) return 2;
        if (a[10:8] == 3'd4) return 1;
        return 0;
    endfunction

    // joysticks arrive as {buttons, up, down, left, right}
    function automatic cab_port_u cab_expect(input logic [1:0] sel);
        cab_port_u  c;
        logic [5:0] j;
        c = dipsw_a;
        j = (sel == 2'd1) ? joystick1 : joystick2;
        if (sel == 2'd0) begin
            c.sys.fill    = 3'b111;
            c.sys.start   = start_button;
            c.sys.service = service;
            c.sys.coin    = coin_input;
        end else if (sel != 2'd3) begin
            c.joy.fill   = 2'b11;
            c.joy.button = j[5:4];
            c.joy.up     = j[3];
            c.joy.down   = j[2];
            c.joy.left   = j[1];
            c.joy.right  = j[0];
        end
        return c;
    endfunction

    task automatic add_test(input string name, input op_e op, input logic [15:0] a,
                            input logic [7:0] wd, input logic pause, input int rom_dly,
                            input int rdy_dly, input kind_e kind, input logic [7:0] exp);
        test_t t;
        t.name    = name;
        t.op      = op;
        t.addr    = a;
        t.wdata   = wd;
        t.pause   = pause;
        t.rom_dly = rom_dly;
        t.rdy_dly = rdy_dly;
        t.kind    = kind;
        t.exp     = exp;
        tests.push_back(t);
    endtask

    task automatic randomize_switches();
        rng          = xorshift_next(rng);
        joystick1    = rng[5:0];
        joystick2    = rng[11:6];
        start_button = rng[13:12];
        coin_input   = rng[15:14];
        service      = rng[16];
        dipsw_a      = rng[24:17];
        dipsw_c      = rng[28:25];
        rng          = xorshift_next(rng);
        dipsw_b      = rng[7:0];
    endtask

    // one cpu access, waits for ready and checks latency, selects and strobes
    task automatic bus_access(input test_t t);
        int n;
        int chip;
        int p1;
        int p2;
        int p_at;
        int lat;
        chip     = strobe_chip(t.addr, t.op == op_read);
        addr     = t.addr;
        rnw      = (t.op == op_read);
        wdata    = t.wdata;
        valid    = 1'b1;
        rom_ok   = (t.rom_dly == 0);
        psg1_rdy = (chip != 1) || (t.rdy_dly == 0);
        psg2_rdy = (chip != 2) || (t.rdy_dly == 0);
        #1;
        check_byte({t.name, " selects"}, {3'b000, select_expect(t.addr, rnw)},
                   {3'b000, rom_cs, vram_cs, vscr_cs, obj1_cs, obj2_cs});
        n    = 0;
        p1   = 0;
        p2   = 0;
        p_at = 0;
        while (!ready && n < access_max) begin
            @(posedge clk);
            #5;
            n++;
            if (psg1_wr) p1++;
            if (psg2_wr) p2++;
            if (psg1_wr || psg2_wr) p_at = n;
            rom_ok = (n >= t.rom_dly);
            if (n >= t.rdy_dly) begin
                psg1_rdy = 1'b1;
                psg2_rdy = 1'b1;
            end
        end
        if (!ready) begin
            $display("no ready from the DUT within %0d cycles in %s", access_max, t.name);
            $display("Simulation failed");
            $fatal(1, "bus access without ready");
        end
        if (rnw && t.addr[15:14] != 2'b00) lat = t.rom_dly + 1;
        else if (chip != 0 && t.rdy_dly > 0) lat = t.rdy_dly + 3;   // stall, pulse, ready
        else lat = 2;
        check_byte({t.name, " latency"}, 8'(lat), 8'(n));
        valid  = 1'b0;
        rom_ok = 1'b0;
        check_byte({t.name, " psg1 pulses"}, 8'(chip == 1), 8'(p1));
        check_byte({t.name, " psg2 pulses"}, 8'(chip == 2), 8'(p2));
        if (chip != 0) check_byte({t.name, " pulse cycle"}, 8'(t.rdy_dly + 1), 8'(p_at));
        @(posedge clk);
        #5;
        check_bit({t.name, " psg1_wr idle"}, 1'b0, psg1_wr);
        check_bit({t.name, " psg2_wr idle"}, 1'b0, psg2_wr);
    endtask

    // falling lvbl or rising v16, then back
    task automatic video_edge(input logic on_v16);
        if (on_v16) v16 = 1'b1;
        else lvbl = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        v16  = 1'b0;
        lvbl = 1'b1;
        repeat (2) @(posedge clk);
        #5;
    endtask

    task automatic check_result(input test_t t);
        case (t.kind)
            k_data:  check_byte(t.name, t.exp, rdata);
            k_rom:   check_byte(t.name, rom_byte(t.addr), rdata);
            k_dip2:  check_byte(t.name, dipsw_b, rdata);
            k_dip3:  check_byte(t.name, {4'hf, dipsw_c}, rdata);
            k_cab:   check_cab(t.name, cab_expect(t.addr[1:0]), rdata);
            k_flip:  check_bit(t.name, t.exp[0], flip);
            k_pal:   check_byte(t.name, t.exp, 8'(pal_sel));
            k_irq:   check_bit(t.name, t.exp[0], irq_n);
            k_firq:  check_bit(t.name, t.exp[0], firq_n);
            k_psg1:  check_byte(t.name, t.exp, psg1_din);
            k_psg2:  check_byte(t.name, t.exp, psg2_din);
            default: ;
        endcase
    endtask

    // ends the run when the table takes longer than its worst case
    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles before the test table finished", cycles);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin
        int max_dly;
        addr      = 16'h0000;
        rnw       = 1'b1;
        valid     = 1'b0;
        wdata     = 8'h00;
        rom_ok    = 1'b0;
        vram_dout = 8'h5a;
        vscr_dout = 8'h3c;
        obj_dout  = 8'ha7;
        dip_pause = 1'b1;
        lvbl      = 1'b1;
        v16       = 1'b0;
        psg1_rdy  = 1'b1;
        psg2_rdy  = 1'b1;
        randomize_switches();

        add_test("rom wait 0", op_read, 16'h4000, 8'h00, 1, 0, 0, k_rom, 8'h00);
        add_test("rom wait 3", op_read, 16'h8123, 8'h00, 1, 3, 0, k_rom, 8'h00);
        add_test("rom wait 6", op_read, 16'hfffe, 8'h00, 1, 6, 0, k_rom, 8'h00);
        add_test("vram read", op_read, 16'h3800, 8'h00, 1, 0, 0, k_data, 8'h5a);
        add_test("vram read top", op_read, 16'h3fff, 8'h00, 1, 0, 0, k_data, 8'h5a);
        add_test("intshow read", op_read, 16'h0200, 8'h00, 1, 0, 0, k_data, 8'h3c);
        add_test("vscr read", op_read, 16'h2000, 8'h00, 1, 0, 0, k_data, 8'hff);
        add_test("obj1 read", op_read, 16'h2800, 8'h00, 1, 0, 0, k_data, 8'ha7);
        add_test("obj2 read", op_read, 16'h3000, 8'h00, 1, 0, 0, k_data, 8'ha7);
        add_test("dip2 read", op_read, 16'h0500, 8'h00, 1, 0, 0, k_dip2, 8'h00);
        add_test("dip3 read", op_read, 16'h0600, 8'h00, 1, 0, 0, k_dip3, 8'h00);
        add_test("iow read", op_read, 16'h0000, 8'h00, 1, 0, 0, k_data, 8'hff);
        add_test("watchdog read", op_read, 16'h0100, 8'h00, 1, 0, 0, k_data, 8'hff);
        add_test("psg1 strobe read", op_read, 16'h0400, 8'h00, 1, 0, 0, k_data, 8'hff);
        add_test("psg2 data read", op_read, 16'h0800, 8'h00, 1, 0, 0, k_data, 8'hff);
        add_test("color read", op_read, 16'h1800, 8'h00, 1, 0, 0, k_data, 8'hff);
        add_test("system port", op_read, 16'h0700, 8'h00, 1, 0, 0, k_cab, 8'h00);
        add_test("joystick 1 a", op_read, 16'h0701, 8'h00, 1, 0, 0, k_cab, 8'h00);
        add_test("joystick 1 b", op_read, 16'h0701, 8'h00, 1, 0, 0, k_cab, 8'h00);
        add_test("joystick 2 a", op_read, 16'h0702, 8'h00, 1, 0, 0, k_cab, 8'h00);
        add_test("joystick 2 b", op_read, 16'h0702, 8'h00, 1, 0, 0, k_cab, 8'h00);
        add_test("dipsw_a port", op_read, 16'h0703, 8'h00, 1, 0, 0, k_cab, 8'h00);
        add_test("flip on", op_write, 16'h0000, 8'h01, 1, 0, 0, k_flip, 8'h01);
        add_test("flip off", op_write, 16'h0000, 8'h00, 1, 0, 0, k_flip, 8'h00);
        add_test("palette 5", op_write, 16'h1800, 8'hfd, 1, 0, 0, k_pal, 8'h05);
        add_test("palette 2", op_write, 16'h1800, 8'h0a, 1, 0, 0, k_pal, 8'h02);
        add_test("vram write", op_write, 16'h3800, 8'h33, 1, 0, 0, k_none, 8'h00);
        add_test("enable irqs", op_write, 16'h0000, 8'h06, 1, 0, 0, k_irq, 8'h01);
        add_test("vblank irq", op_lvbl, 16'h0000, 8'h00, 1, 0, 0, k_irq, 8'h00);
        add_test("v16 firq", op_v16, 16'h0000, 8'h00, 1, 0, 0, k_firq, 8'h00);
        add_test("irq release", op_write, 16'h0000, 8'h02, 1, 0, 0, k_irq, 8'h01);
        add_test("firq release", op_write, 16'h0000, 8'h00, 1, 0, 0, k_firq, 8'h01);
        add_test("enable again", op_write, 16'h0000, 8'h06, 1, 0, 0, k_irq, 8'h01);
        add_test("paused vblank", op_lvbl, 16'h0000, 8'h00, 0, 0, 0, k_irq, 8'h01);
        add_test("paused v16", op_v16, 16'h0000, 8'h00, 0, 0, 0, k_firq, 8'h01);
        add_test("psg1 data", op_write, 16'h1000, 8'h81, 1, 0, 0, k_psg1, 8'h81);
        add_test("psg1 strobe", op_write, 16'h0400, 8'h00, 1, 0, 0, k_psg1, 8'h81);
        add_test("psg1 busy 1", op_write, 16'h0400, 8'h00, 1, 0, 1, k_psg1, 8'h81);
        add_test("psg1 busy 4", op_write, 16'h0400, 8'h00, 1, 0, 4, k_psg1, 8'h81);
        add_test("psg2 data", op_write, 16'h0800, 8'h4e, 1, 0, 0, k_psg2, 8'h4e);
        add_test("psg2 busy 2", op_write, 16'h0300, 8'h00, 1, 0, 2, k_psg2, 8'h4e);
        add_test("psg2 strobe", op_write, 16'h0300, 8'h00, 1, 0, 0, k_psg2, 8'h4e);

        max_dly = 0;
        foreach (tests[i]) begin
            if (tests[i].rom_dly > max_dly) max_dly = tests[i].rom_dly;
            if (tests[i].rdy_dly > max_dly) max_dly = tests[i].rdy_dly;
        end
        access_max  = 10 + max_dly;
        cycle_limit = tests.size() * access_max + rst_cyc;

        rst = 1'b1;
        repeat (rst_cyc) @(posedge clk);
        #5;
        rst = 1'b0;
        check_bit("reset irq_n", 1'b1, irq_n);
        check_bit("reset firq_n", 1'b1, firq_n);
        check_bit("reset flip", 1'b0, flip);
        check_bit("reset ready", 1'b0, ready);

        foreach (tests[i]) begin
            randomize_switches();
            dip_pause = tests[i].pause;
            case (tests[i].op)
                op_lvbl: video_edge(1'b0);
                op_v16:  video_edge(1'b1);
                default: bus_access(tests[i]);
            endcase
            check_result(tests[i]);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- kicker_io.f
+incdir+include
hw/kicker_io_pkg.sv
hw/kicker_bus_decode.sv
hw/kicker_ctrl_exec.sv
hw/kicker_read_mux.sv
hw/kicker_io_top.sv
sim/kicker_io_props.sv
sim/kicker_io_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= kicker_io_tb
FILELIST  ?= kicker_io.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
